// ==== common/spr_pkg.sv ====
////////////////////
// sprite block shared definitions
// raster window constants, object and slot memory layouts
////////////////////
`default_nettype none

package spr_pkg;

  localparam int SLOT_CNT      = 8;    // sprites drawn per line
  localparam int OAM_BYTES     = 256;
  localparam int FETCH_START_X = 256;  // first pattern fetch position
  localparam int LINE_END_X    = 320;  // found count clears here
  localparam int LAST_EVAL_Y   = 239;

  typedef logic [2:0] slot_idx_t;

  // raster position, driven from outside the block
  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] y_next;
    logic       pix_pulse;  // one clock before x moves on
  } raster_t;

  typedef struct packed {
    logic       v_flip;
    logic       h_flip;
    logic       prio;     // 1 puts the sprite behind the playfield
    logic [2:0] rsvd;
    logic [1:0] palette;
  } oam_attr_t;

  // one object, byte 0 in the top bits
  typedef struct packed {
    logic [7:0] y;        // top row minus one
    logic [7:0] tile;
    oam_attr_t  attr;
    logic [7:0] x;
  } oam_entry_t;

  // temporary memory entry, one per found sprite
  typedef struct packed {
    logic       primary;  // came from oam entry 0
    logic [7:0] tile;
    logic [7:0] x;
    logic [1:0] palette;
    logic       prio;
    logic       h_flip;
    logic [2:0] row;      // v_flip already applied
  } stm_entry_t;

  // buffer memory entry, ready for the shifters
  typedef struct packed {
    logic       primary;
    logic       prio;
    logic [1:0] palette;
    logic [7:0] pd1;
    logic [7:0] pd0;
    logic [7:0] x;
  } sbm_entry_t;

endpackage

`default_nettype wire

// ==== logic/oam_ram.sv ====
////////////////////
// object attribute memory
// cpu byte port plus a four byte entry read for evaluation
////////////////////
`timescale 1ns/1ps
`default_nettype none

module oam_ram
(
  input  logic               clk_in,
  input  logic [7:0]         addr,
  input  logic               wr,
  input  logic [7:0]         wdata,
  output logic [7:0]         rdata,
  input  logic [5:0]         entry_idx,
  output spr_pkg::oam_entry_t entry
);

  import spr_pkg::*;

  logic [7:0] mem [OAM_BYTES];

  always_ff @(posedge clk_in)
  begin
    if (wr)
      mem[addr] <= wdata;
  end

  assign rdata = mem[addr];  // cpu readback

  // y, tile, attr, x in byte order
  assign entry = {mem[{entry_idx, 2'd0}],
                  mem[{entry_idx, 2'd1}],
                  mem[{entry_idx, 2'd2}],
                  mem[{entry_idx, 2'd3}]};

endmodule

`default_nettype wire

// ==== logic/spr_slot_ram.sv ====
////////////////////
// eight entry slot memory
// one indexed read, plus the whole array for parallel readers
////////////////////
`timescale 1ns/1ps
`default_nettype none

module spr_slot_ram
#(
  parameter type entry_t = logic [7:0]
)
(
  input  logic               clk_in,
  input  logic               wr,
  input  spr_pkg::slot_idx_t waddr,
  input  entry_t             wdata,
  input  spr_pkg::slot_idx_t raddr,
  output entry_t             rdata,
  output entry_t             all_q [spr_pkg::SLOT_CNT]
);

  import spr_pkg::*;

  entry_t mem [SLOT_CNT];

  always_ff @(posedge clk_in)
  begin
    if (wr)
      mem[waddr] <= wdata;
  end

  assign rdata = mem[raddr];
  assign all_q = mem;  // every slot, for the render shifters

endmodule

`default_nettype wire

// ==== spr_eval/spr_eval.sv ====
////////////////////
// sprite evaluation
// finds up to eight objects in range on the next line
////////////////////
`timescale 1ns/1ps
`default_nettype none

module spr_eval
(
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                en,
  input  spr_pkg::raster_t    raster,
  output logic [5:0]          oam_idx,
  input  spr_pkg::oam_entry_t oam_entry,
  output logic                stm_wr,
  output spr_pkg::slot_idx_t  stm_waddr,
  output spr_pkg::stm_entry_t stm_wdata,
  output logic [3:0]          found_cnt,
  output logic                overflow
);

  import spr_pkg::*;

  logic [3:0] cnt_q;
  logic       ovf_q;
  logic [7:0] y_top;     // first row the sprite covers
  logic [8:0] rng_diff;
  logic       in_rng;
  logic       eval_slot;
  logic       line_end;

  assign oam_idx = raster.x[7:2];  // one object every four pixels

  assign y_top    = oam_entry.y + 8'd1;
  assign rng_diff = raster.y_next[8:0] - {1'b0, y_top};
  assign in_rng   = (rng_diff < 9'd8);

  assign eval_slot = en && raster.pix_pulse && (raster.y_next < LAST_EVAL_Y);
  assign line_end  = eval_slot && (raster.x == LINE_END_X);

  // store while the temporary memory still has room
  assign stm_wr    = eval_slot && (raster.x < FETCH_START_X) && (raster.x[1:0] == 2'b00) &&
                     in_rng && !cnt_q[3];
  assign stm_waddr = cnt_q[2:0];

  always_comb
  begin
    stm_wdata.primary = (oam_idx == 6'd0);
    stm_wdata.tile    = oam_entry.tile;
    stm_wdata.x       = oam_entry.x;
    stm_wdata.palette = oam_entry.attr.palette;
    stm_wdata.prio    = oam_entry.attr.prio;
    stm_wdata.h_flip  = oam_entry.attr.h_flip;
    stm_wdata.row     = oam_entry.attr.v_flip ? ~rng_diff[2:0] : rng_diff[2:0];
  end

  ////////////////////
  // found count and overflow

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      cnt_q <= 4'd0;
      ovf_q <= 1'b0;
    end
    else
    begin
      if (line_end)
        cnt_q <= 4'd0;
      else if (stm_wr)
        cnt_q <= cnt_q + 4'd1;

      if ((raster.x == 10'd0) && (raster.y_next == 10'd0))
        ovf_q <= 1'b0;  // new frame
      else if (cnt_q[3])
        ovf_q <= 1'b1;
    end
  end

  assign found_cnt = cnt_q;
  assign overflow  = ovf_q;

  // the count only ever climbs one step per object, and stops at a full line
  a_cnt_max : assert property (@(posedge clk_in) disable iff (rst_in)
    cnt_q <= 4'(SLOT_CNT))
    else $error("found count above slot count");

endmodule

`default_nettype wire

// ==== spr_fetch/spr_fetch.sv ====
////////////////////
// pattern fetch
// reads two pattern planes per found sprite into the buffer memory
////////////////////
`timescale 1ns/1ps
`default_nettype none

module spr_fetch
(
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                en,
  input  spr_pkg::raster_t    raster,
  input  logic                pt_sel,
  input  logic [3:0]          found_cnt,
  output spr_pkg::slot_idx_t  stm_raddr,
  input  spr_pkg::stm_entry_t stm_entry,
  output logic [13:0]         vram_a,
  output logic                vram_req,
  input  logic [7:0]          vram_d,
  output logic                sbm_wr,
  output spr_pkg::slot_idx_t  sbm_waddr,
  output spr_pkg::sbm_entry_t sbm_wdata
);

  import spr_pkg::*;

  logic [7:0] pd0_q;
  logic [7:0] pd1_q;
  logic [7:0] vram_ord;  // pattern byte in display order
  logic       in_win;
  logic       slot_vld;

  assign stm_raddr = raster.x[5:3];  // eight pixels per slot

  assign in_win   = en && (raster.y_next < LAST_EVAL_Y) &&
                    (raster.x >= FETCH_START_X) && (raster.x < LINE_END_X);
  assign slot_vld = ({1'b0, stm_raddr} < found_cnt);

  // plane select comes straight from x bit 1
  assign vram_a   = {1'b0, pt_sel, stm_entry.tile, raster.x[1], stm_entry.row};
  assign vram_req = in_win && slot_vld && !raster.x[2];  // phases 0 and 1

  // shifters send bit 0 first, so an unflipped byte gets reversed
  assign vram_ord = stm_entry.h_flip ? vram_d : {<<{vram_d}};

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      pd0_q <= 8'h00;
      pd1_q <= 8'h00;
    end
    else if (vram_req)
    begin
      if (raster.x[1])
        pd1_q <= vram_ord;
      else
        pd0_q <= vram_ord;
    end
  end

  ////////////////////
  // buffer memory write

  // unused slots get a blank entry so old data never shows
  assign sbm_wr    = in_win && (!slot_vld || (raster.x[2:1] == 2'd2));
  assign sbm_waddr = stm_raddr;

  always_comb
  begin
    sbm_wdata = '0;
    if (slot_vld)
    begin
      sbm_wdata.primary = stm_entry.primary;
      sbm_wdata.prio    = stm_entry.prio;
      sbm_wdata.palette = stm_entry.palette;
      sbm_wdata.pd1     = pd1_q;
      sbm_wdata.pd0     = pd0_q;
      sbm_wdata.x       = stm_entry.x;
    end
  end

  // the vram port belongs to the sprite block only during x 256..319
  a_req_window : assert property (@(posedge clk_in) disable iff (rst_in)
    vram_req |-> (raster.x >= FETCH_START_X) && (raster.x < LINE_END_X) &&
                 (raster.y_next < LAST_EVAL_Y))
    else $error("vram request outside fetch window");

endmodule

`default_nettype wire

// ==== spr_render/spr_render.sv ====
////////////////////
// sprite pixel output
// eight pattern shifters, lowest opaque slot wins
////////////////////
`timescale 1ns/1ps
`default_nettype none

module spr_render
(
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                en,
  input  spr_pkg::raster_t    raster,
  input  spr_pkg::sbm_entry_t sbm_all [spr_pkg::SLOT_CNT],
  output logic [3:0]          palette_idx,
  output logic                primary,
  output logic                prio
);

  import spr_pkg::*;

  logic [7:0] pd0_sh [SLOT_CNT];
  logic [7:0] pd1_sh [SLOT_CNT];

  ////////////////////
  // shifters

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < SLOT_CNT; i++)
      begin
        pd0_sh[i] <= 8'h00;
        pd1_sh[i] <= 8'h00;
      end
    end
    else if (en && (raster.y < LAST_EVAL_Y))
    begin
      for (int i = 0; i < SLOT_CNT; i++)
      begin
        if (raster.pix_pulse)
        begin
          pd0_sh[i] <= {1'b0, pd0_sh[i][7:1]};
          pd1_sh[i] <= {1'b0, pd1_sh[i][7:1]};
        end
        else if (raster.x[7:0] == sbm_all[i].x)
        begin
          // sprite starts at this pixel
          pd0_sh[i] <= sbm_all[i].pd0;
          pd1_sh[i] <= sbm_all[i].pd1;
        end
      end
    end
  end

  ////////////////////
  // slot priority

  // walk from the top slot down so the lowest opaque one is left standing
  always_comb
  begin
    palette_idx = 4'h0;
    primary     = 1'b0;
    prio        = 1'b0;
    if (en)
    begin
      for (int i = SLOT_CNT - 1; i >= 0; i--)
      begin
        if ({pd1_sh[i][0], pd0_sh[i][0]} != 2'b00)
        begin
          palette_idx = {sbm_all[i].palette, pd1_sh[i][0], pd0_sh[i][0]};
          primary     = sbm_all[i].primary;
          prio        = sbm_all[i].prio;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ppu_spr.sv ====
////////////////////
// ppu sprite block top
// object memory, slot memories and the eval, fetch, render stages
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ppu_spr
(
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             en_in,          // sprites on
  input  logic             spr_pt_sel_in,  // sprite pattern table
  input  logic [7:0]       oam_a_in,
  input  logic [7:0]       oam_d_in,
  input  logic             oam_wr_in,
  output logic [7:0]       oam_d_out,
  input  spr_pkg::raster_t raster_in,
  input  logic [7:0]       vram_d_in,
  output logic [13:0]      vram_a_out,
  output logic             vram_req_out,
  output logic             overflow_out,
  output logic [3:0]       palette_idx_out,
  output logic             primary_out,
  output logic             priority_out
);

  import spr_pkg::*;

  logic [5:0] oam_idx;
  oam_entry_t oam_entry;
  logic       stm_wr;
  slot_idx_t  stm_waddr;
  stm_entry_t stm_wdata;
  slot_idx_t  stm_raddr;
  stm_entry_t stm_rdata;
  logic [3:0] found_cnt;
  logic       sbm_wr;
  slot_idx_t  sbm_waddr;
  sbm_entry_t sbm_wdata;
  sbm_entry_t sbm_all [SLOT_CNT];

  oam_ram oam0 (
    .clk_in    (clk_in),
    .addr      (oam_a_in),
    .wr        (oam_wr_in),
    .wdata     (oam_d_in),
    .rdata     (oam_d_out),
    .entry_idx (oam_idx),
    .entry     (oam_entry)
  );

  spr_slot_ram #(.entry_t(stm_entry_t)) stm0 (
    .clk_in (clk_in),
    .wr     (stm_wr),
    .waddr  (stm_waddr),
    .wdata  (stm_wdata),
    .raddr  (stm_raddr),
    .rdata  (stm_rdata),
    .all_q  ()
  );

  // render reads every slot at once, the indexed port sits idle
  spr_slot_ram #(.entry_t(sbm_entry_t)) sbm0 (
    .clk_in (clk_in),
    .wr     (sbm_wr),
    .waddr  (sbm_waddr),
    .wdata  (sbm_wdata),
    .raddr  ('0),
    .rdata  (),
    .all_q  (sbm_all)
  );

  spr_eval eval0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .en        (en_in),
    .raster    (raster_in),
    .oam_idx   (oam_idx),
    .oam_entry (oam_entry),
    .stm_wr    (stm_wr),
    .stm_waddr (stm_waddr),
    .stm_wdata (stm_wdata),
    .found_cnt (found_cnt),
    .overflow  (overflow_out)
  );

  spr_fetch fetch0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .en        (en_in),
    .raster    (raster_in),
    .pt_sel    (spr_pt_sel_in),
    .found_cnt (found_cnt),
    .stm_raddr (stm_raddr),
    .stm_entry (stm_rdata),
    .vram_a    (vram_a_out),
    .vram_req  (vram_req_out),
    .vram_d    (vram_d_in),
    .sbm_wr    (sbm_wr),
    .sbm_waddr (sbm_waddr),
    .sbm_wdata (sbm_wdata)
  );

  spr_render render0 (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .en          (en_in),
    .raster      (raster_in),
    .sbm_all     (sbm_all),
    .palette_idx (palette_idx_out),
    .primary     (primary_out),
    .prio        (priority_out)
  );

endmodule

`default_nettype wire

// ==== verif/tb_ppu_spr.sv ====
////////////////////
// ppu sprite block testbench
// short raster with a vram model, checks fetch, pixels and flags
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_spr;

  import spr_pkg::*;

  localparam int FRAME_LINES = 24;                   // y runs 0..23 and y_next wraps to 0
  localparam int LINES_RUN   = 2 * FRAME_LINES + 3;  // two frames and three lines with sprites off
  localparam int TIMEOUT_CYC = LINES_RUN * 682 * 2;

  logic        clk_in;
  logic        rst_in;
  logic        en_in;
  logic        spr_pt_sel_in;
  logic [7:0]  oam_a_in;
  logic [7:0]  oam_d_in;
  logic        oam_wr_in;
  logic [7:0]  oam_d_out;
  raster_t     raster_in;
  logic [7:0]  vram_d_in;
  logic [13:0] vram_a_out;
  logic        vram_req_out;
  logic        overflow_out;
  logic [3:0]  palette_idx_out;
  logic        primary_out;
  logic        priority_out;

  // reference state and expected values
  logic [7:0]  oam_ref [OAM_BYTES];
  logic [7:0]  exp_oam_d;
  logic        oam_chk;
  logic        exp_req;
  logic [13:0] exp_a;
  logic        pix_chk;
  logic [3:0]  exp_pal;
  logic        exp_prim;
  logic        exp_prio;
  logic        ovf_chk;
  logic        exp_ovf;
  logic [31:0] lfsr;
  int          err_oam;
  int          err_fetch;
  int          err_pix;
  int          err_ovf;
  int          cyc_cnt = 0;

  // fl holds the line under evaluation and rl the line on screen
  int fl_cnt;
  int fl_idx [SLOT_CNT];
  int fl_row [SLOT_CNT];
  int rl_cnt;
  int rl_idx [SLOT_CNT];
  int rl_row [SLOT_CNT];

  ppu_spr dut0 (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .en_in           (en_in),
    .spr_pt_sel_in   (spr_pt_sel_in),
    .oam_a_in        (oam_a_in),
    .oam_d_in        (oam_d_in),
    .oam_wr_in       (oam_wr_in),
    .oam_d_out       (oam_d_out),
    .raster_in       (raster_in),
    .vram_d_in       (vram_d_in),
    .vram_a_out      (vram_a_out),
    .vram_req_out    (vram_req_out),
    .overflow_out    (overflow_out),
    .palette_idx_out (palette_idx_out),
    .primary_out     (primary_out),
    .priority_out    (priority_out)
  );

  assign vram_d_in = vram_a_out[7:0] ^ 8'h5A;  // pattern memory model answers in the same cycle
  assign exp_oam_d = oam_ref[oam_a_in];

  initial
  begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  always @(posedge clk_in)
  begin
    cyc_cnt <= cyc_cnt + 1;
  end

  initial
  begin
    wait (cyc_cnt >= TIMEOUT_CYC);
    $display("timeout: raster run did not end within %0d cycles", TIMEOUT_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // checks

  a_oam_rd : assert property (@(posedge clk_in) disable iff (rst_in)
    (oam_chk && !oam_wr_in) |-> (oam_d_out == exp_oam_d))
    else
    begin
      err_oam++;
      $display("ERR oam_d_out addr %h got %h exp %h", $sampled(oam_a_in),
               $sampled(oam_d_out), $sampled(exp_oam_d));
    end

  a_req : assert property (@(posedge clk_in) disable iff (rst_in) vram_req_out == exp_req)
    else
    begin
      err_fetch++;
      $display("ERR vram_req_out got %h exp %h", $sampled(vram_req_out), $sampled(exp_req));
    end

  a_addr : assert property (@(posedge clk_in) disable iff (rst_in)
    exp_req |-> (vram_a_out == exp_a))
    else
    begin
      err_fetch++;
      $display("ERR vram_a_out got %h exp %h", $sampled(vram_a_out), $sampled(exp_a));
    end

  a_pal : assert property (@(posedge clk_in) disable iff (rst_in)
    pix_chk |-> (palette_idx_out == exp_pal))
    else
    begin
      err_pix++;
      $display("ERR palette_idx_out x %h got %h exp %h", $sampled(raster_in.x),
               $sampled(palette_idx_out), $sampled(exp_pal));
    end

  a_prim : assert property (@(posedge clk_in) disable iff (rst_in)
    pix_chk |-> (primary_out == exp_prim))
    else
    begin
      err_pix++;
      $display("ERR primary_out got %h exp %h", $sampled(primary_out), $sampled(exp_prim));
    end

  a_prio : assert property (@(posedge clk_in) disable iff (rst_in)
    pix_chk |-> (priority_out == exp_prio))
    else
    begin
      err_pix++;
      $display("ERR priority_out got %h exp %h", $sampled(priority_out), $sampled(exp_prio));
    end

  a_ovf : assert property (@(posedge clk_in) disable iff (rst_in)
    ovf_chk |-> (overflow_out == exp_ovf))
    else
    begin
      err_ovf++;
      $display("ERR overflow_out got %h exp %h", $sampled(overflow_out), $sampled(exp_ovf));
    end

  ////////////////////
  // helpers

  task automatic take_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
    end
  endtask

  function automatic logic [7:0] oam_byte(input int e, input int b);
    oam_byte = oam_ref[8'(4 * e + b)];
  endfunction

  task automatic oam_write(input logic [7:0] a, input logic [7:0] d);
    @(negedge clk_in);
    oam_a_in   = a;
    oam_d_in   = d;
    oam_wr_in  = 1'b1;
    oam_ref[a] = d;
    oam_chk    = 1'b1;
    @(negedge clk_in);
    oam_wr_in  = 1'b0;  // address stays so the readback shows on the next edge
  endtask

  task automatic load_oam();
    logic [7:0] y_top;
    logic [7:0] tile;
    logic [7:0] attr;
    logic [7:0] xs;
    for (int e = 0; e < OAM_BYTES / 4; e++)
    begin
      take_bits(4, y_top);
      take_bits(8, tile);
      take_bits(8, attr);
      take_bits(8, xs);
      if (e == 1)
      begin
        y_top = oam_byte(0, 0) + 8'd1;  // overlaps entry 0
        xs    = oam_byte(0, 3) + 8'd3;
      end
      if (e >= 2 && e <= 5)
        attr[7:6] = 2'(e - 2);  // each flip combination
      if (e >= 12 && e < 22)
        y_top = 8'd12;          // ten sprites on rows 12..19
      else if (e >= 22)
        y_top = 8'hF1;          // never in range
      oam_write(8'(4 * e), y_top - 8'd1);
      oam_write(8'(4 * e + 1), tile);
      oam_write(8'(4 * e + 2), attr);
      oam_write(8'(4 * e + 3), xs);
    end
  endtask

  // first eight objects in range on row n with the row already flipped
  task automatic find_sprites(input int n);
    logic [7:0] y_top;
    logic [7:0] attr;
    logic [8:0] diff;
    fl_cnt = 0;
    for (int e = 0; e < OAM_BYTES / 4; e++)
    begin
      y_top = oam_byte(e, 0) + 8'd1;
      attr  = oam_byte(e, 2);
      diff  = 9'(n) - {1'b0, y_top};
      if (diff < 9'd8 && fl_cnt < SLOT_CNT)
      begin
        fl_idx[3'(fl_cnt)] = e;
        fl_row[3'(fl_cnt)] = attr[7] ? 7 - int'(diff[2:0]) : int'(diff[2:0]);
        fl_cnt++;
      end
    end
  endtask

  // {palette, plane bits, primary, priority} of the lowest opaque slot
  function automatic logic [5:0] pixel_model(input int x);
    int         e;
    int         i;
    logic [2:0] bi;
    logic [7:0] attr;
    logic [7:0] tile;
    logic [7:0] pd0;
    logic [7:0] pd1;
    logic       b0;
    logic       b1;
    logic       hit;
    pixel_model = 6'd0;
    hit         = 1'b0;
    for (int s = 0; s < rl_cnt; s++)
    begin
      e = rl_idx[3'(s)];
      i = x - int'(oam_byte(e, 3));
      if (!hit && i >= 0 && i < 8)
      begin
        attr = oam_byte(e, 2);
        tile = oam_byte(e, 1);
        bi   = 3'(i);
        pd0  = {tile[3:0], 1'b0, 3'(rl_row[3'(s)])} ^ 8'h5A;
        pd1  = {tile[3:0], 1'b1, 3'(rl_row[3'(s)])} ^ 8'h5A;
        b0   = attr[6] ? pd0[bi] : pd0[~bi];
        b1   = attr[6] ? pd1[bi] : pd1[~bi];
        if (b0 || b1)
        begin
          hit         = 1'b1;
          pixel_model = {attr[1:0], b1, b0, (e == 0), attr[5]};
        end
      end
    end
  endfunction

  // one raster line that holds each x two clocks and pulses pix_pulse in the second
  task automatic run_line(input int y, input int y_next, input logic fetched,
                          input logic en, input logic pt_sel);
    logic [5:0] pix;
    int         slot;
    rl_cnt = fl_cnt;
    rl_idx = fl_idx;
    rl_row = fl_row;
    find_sprites(y_next);
    for (int x = 0; x <= 340; x++)
    begin
      for (int ph = 0; ph < 2; ph++)
      begin
        @(negedge clk_in);
        en_in               = en;
        spr_pt_sel_in       = pt_sel;
        raster_in.x         = 10'(x);
        raster_in.y         = 10'(y);
        raster_in.y_next    = 10'(y_next);
        raster_in.pix_pulse = (ph == 1);
        if (x == 0 && y_next == 0)
          exp_ovf = 1'b0;  // new frame
        if (x == FETCH_START_X && en && fl_cnt == SLOT_CNT)
          exp_ovf = 1'b1;
        slot    = (x >> 3) & 7;
        exp_req = en && (x >= FETCH_START_X) && (x < LINE_END_X) && !x[2] && (slot < fl_cnt);
        if (exp_req)
          exp_a = {1'b0, pt_sel, oam_byte(fl_idx[3'(slot)], 1), x[1],
                   3'(fl_row[3'(slot)])};
        // sprites loaded late in the line spill into the left edge
        pix_chk = (ph == 1) && (x >= 8) && (x < 256) && (fetched || !en);
        pix     = en ? pixel_model(x) : 6'd0;
        {exp_pal, exp_prim, exp_prio} = pix;
        ovf_chk = (ph == 1) && (x == 2 || x == 330);
      end
    end
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    lfsr             = 32'he6e2_835d;
    rst_in           = 1'b1;
    en_in            = 1'b1;
    spr_pt_sel_in    = 1'b0;
    oam_a_in         = 8'h00;
    oam_d_in         = 8'h00;
    oam_wr_in        = 1'b0;
    raster_in        = '0;
    raster_in.x      = 10'd330;  // parked outside every window
    raster_in.y_next = 10'd1;
    oam_chk          = 1'b0;
    exp_req          = 1'b0;
    exp_a            = 14'h0000;
    pix_chk          = 1'b0;
    exp_pal          = 4'h0;
    exp_prim         = 1'b0;
    exp_prio         = 1'b0;
    ovf_chk          = 1'b0;
    exp_ovf          = 1'b0;
    err_oam          = 0;
    err_fetch        = 0;
    err_pix          = 0;
    err_ovf          = 0;
    fl_cnt           = 0;
    repeat (16) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    load_oam();
    for (int ln = 0; ln < LINES_RUN; ln++)
      run_line(ln % FRAME_LINES, (ln + 1) % FRAME_LINES, ln > 0,
               ln < 2 * FRAME_LINES, ln >= FRAME_LINES);
    @(negedge clk_in);
    pix_chk = 1'b0;
    ovf_chk = 1'b0;
    repeat (2) @(negedge clk_in);
    $display("errors: oam %0d fetch %0d pixel %0d overflow %0d",
             err_oam, err_fetch, err_pix, err_ovf);
    if (err_oam + err_fetch + err_pix + err_ovf == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
common/spr_pkg.sv
logic/oam_ram.sv
logic/spr_slot_ram.sv
spr_eval/spr_eval.sv
spr_fetch/spr_fetch.sv
spr_render/spr_render.sv
logic/ppu_spr.sv
verif/tb_ppu_spr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ppu sprite testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_ppu_spr -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ppu_spr > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
